// File: axi_pkg.sv
`default_nettype none

package axi_pkg;

    localparam int AXI_LEN_W   = 8;
    localparam int AXI_SIZE_W  = 3;
    localparam int AXI_BURST_W = 2;
    localparam int AXI_RESP_W  = 2;

    typedef enum logic [AXI_BURST_W-1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_e;

    // only the two responses this slave ever returns.
    typedef enum logic [AXI_RESP_W-1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

endpackage : axi_pkg

`default_nettype wire

// File: bridge_pkg.sv
`default_nettype none

package bridge_pkg;

    typedef logic [7:0] byte_t;

    typedef enum logic [1:0] {
        IDLE      = 2'd0, // address channel open.
        XFER      = 2'd1, // bytes moving to or from ram.
        WAIT_DATA = 2'd2, // write side only.
        RESP      = 2'd3
    } chan_state_e;

endpackage : bridge_pkg

`default_nettype wire

// File: ram_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ram_if
    import bridge_pkg::*;
#(
    parameter int ADDR_WIDTH = 12
) ();

    logic [ADDR_WIDTH-1:0] addr_a;
    byte_t                 rdata_a;

    logic [ADDR_WIDTH-1:0] addr_b;
    byte_t                 wdata_b;
    logic                  we_b;

    modport rd (
        output addr_a,
        input  rdata_a
    );

    modport wr (
        output addr_b,
        output wdata_b,
        output we_b
    );

    modport mem (
        input  addr_a,
        output rdata_a,
        input  addr_b,
        input  wdata_b,
        input  we_b
    );

endinterface : ram_if

`default_nettype wire

// File: byte_ram.sv
`timescale 1ns/1ps
`default_nettype none

module byte_ram
    import bridge_pkg::*;
#(
    parameter int ADDR_WIDTH = 12
) (
    input  logic   clk,
    ram_if.mem     mem
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    byte_t storage [DEPTH];

    // port a, one cycle read latency.
    always_ff @(posedge clk) begin
        mem.rdata_a <= storage[mem.addr_a];
    end

    always_ff @(posedge clk) begin
        if (mem.we_b) begin
            storage[mem.addr_b] <= mem.wdata_b;
        end
    end

endmodule : byte_ram

`default_nettype wire

// File: beat_counter.sv
`timescale 1ns/1ps
`default_nettype none

module beat_counter
    import axi_pkg::*;
#(
    parameter int ADDR_WIDTH = 12,
    parameter int DATA_WIDTH = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            load,
    input  logic                            step,
    input  logic [ADDR_WIDTH-1:0]           start_addr,
    input  logic [AXI_LEN_W-1:0]            len,
    input  logic [AXI_SIZE_W-1:0]           size,
    input  burst_e                          burst,
    output logic [ADDR_WIDTH-1:0]           byte_addr,
    output logic [$clog2(DATA_WIDTH/8)-1:0] byte_lane,
    output logic                            last_byte,
    output logic                            last_beat
);

    localparam int LANE_W = $clog2(DATA_WIDTH / 8);

    logic [ADDR_WIDTH-1:0] beat_base;
    logic [LANE_W-1:0]     byte_idx;
    logic [AXI_LEN_W-1:0]  beats_left;
    logic [AXI_SIZE_W-1:0] size_q;
    burst_e                burst_q;
    logic [LANE_W:0]       beat_bytes;

    assign beat_bytes = (LANE_W + 1)'(1) << size_q;
    assign last_byte  = ({1'b0, byte_idx} == beat_bytes - 1'b1);
    assign last_beat  = (beats_left == '0);
    assign byte_lane  = byte_addr[LANE_W-1:0]; // lane follows the address offset.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_addr  <= '0;
            beat_base  <= '0;
            byte_idx   <= '0;
            beats_left <= '0;
            size_q     <= '0;
            burst_q    <= FIXED;
        end else if (load) begin
            byte_addr  <= start_addr;
            beat_base  <= start_addr;
            byte_idx   <= '0;
            beats_left <= len;
            size_q     <= size;
            burst_q    <= burst;
        end else if (step) begin
            if (last_byte) begin
                byte_idx   <= '0;
                beats_left <= beats_left - 1'b1;
                if (burst_q == FIXED) begin
                    byte_addr <= beat_base; // same beat address again.
                end else begin
                    byte_addr <= byte_addr + 1'b1;
                    beat_base <= byte_addr + 1'b1;
                end
            end else begin
                byte_idx  <= byte_idx + 1'b1;
                byte_addr <= byte_addr + 1'b1;
            end
        end
    end

    a_start_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        load |-> (start_addr & ~({ADDR_WIDTH{1'b1}} << size)) == '0)
        else $error("start address not aligned to transfer size");

    a_size_fits: assert property (@(posedge clk) disable iff (!rst_n)
        load |-> size <= AXI_SIZE_W'(LANE_W))
        else $error("transfer size wider than the data bus");

endmodule : beat_counter

`default_nettype wire

// File: rd_channel_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module rd_channel_fsm
    import axi_pkg::*;
    import bridge_pkg::*;
#(
    parameter int ADDR_WIDTH = 12,
    parameter int DATA_WIDTH = 32,
    parameter int ID_WIDTH   = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  arvalid,
    output logic                  arready,
    input  logic [ID_WIDTH-1:0]   arid,
    input  logic [ADDR_WIDTH-1:0] araddr,
    input  logic [AXI_LEN_W-1:0]  arlen,
    input  logic [AXI_SIZE_W-1:0] arsize,
    input  burst_e                arburst,
    output logic                  rvalid,
    input  logic                  rready,
    output logic [ID_WIDTH-1:0]   rid,
    output logic [DATA_WIDTH-1:0] rdata,
    output resp_e                 rresp,
    output logic                  rlast,
    ram_if.rd                     ram
);

    localparam int LANE_W = $clog2(DATA_WIDTH / 8);

    chan_state_e           state;
    chan_state_e           state_nxt;
    logic                  wrap_q;
    logic                  issue_done;
    logic                  pend_q;
    logic                  rlast_q;
    logic [LANE_W-1:0]     pend_lane_q;
    logic [ID_WIDTH-1:0]   rid_q;
    logic [DATA_WIDTH-1:0] beat_q;
    logic                  ar_hs;
    logic                  r_hs;
    logic                  issue;
    logic                  cnt_step;
    logic [AXI_SIZE_W-1:0] ld_size;
    logic [ADDR_WIDTH-1:0] byte_addr;
    logic [LANE_W-1:0]     byte_lane;
    logic                  last_byte;
    logic                  last_beat;

    assign ar_hs    = arvalid && arready;
    assign r_hs     = rvalid && rready;
    assign issue    = (state == XFER) && !issue_done;
    assign cnt_step = issue || (r_hs && wrap_q); // wrap bursts count whole beats.
    assign ld_size  = (arburst == WRAP) ? '0 : arsize;

    assign arready     = (state == IDLE);
    assign rvalid      = (state == RESP);
    assign rid         = rid_q;
    assign rdata       = beat_q;
    assign rresp       = resp_e'(wrap_q ? SLVERR : OKAY);
    assign rlast       = wrap_q ? last_beat : rlast_q;
    assign ram.addr_a  = byte_addr;

    beat_counter #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_beat_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (ar_hs),
        .step       (cnt_step),
        .start_addr (araddr),
        .len        (arlen),
        .size       (ld_size),
        .burst      (arburst),
        .byte_addr  (byte_addr),
        .byte_lane  (byte_lane),
        .last_byte  (last_byte),
        .last_beat  (last_beat)
    );

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (ar_hs) begin
                    if (arburst == WRAP) begin
                        state_nxt = RESP;
                    end else begin
                        state_nxt = XFER;
                    end
                end
            end
            XFER: begin
                if (issue_done) begin
                    state_nxt = RESP; // last byte lands this cycle.
                end
            end
            RESP: begin
                if (r_hs) begin
                    if (rlast) begin
                        state_nxt = IDLE;
                    end else if (!wrap_q) begin
                        state_nxt = XFER;
                    end
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            wrap_q     <= 1'b0;
            issue_done <= 1'b0;
            pend_q     <= 1'b0;
            rlast_q    <= 1'b0;
        end else begin
            state  <= state_nxt;
            pend_q <= issue;
            if (ar_hs) begin
                wrap_q <= (arburst == WRAP);
            end
            if (issue_done) begin
                issue_done <= 1'b0;
            end else if (issue && last_byte) begin
                issue_done <= 1'b1;
                rlast_q    <= last_beat;
            end
        end
    end

    always_ff @(posedge clk) begin
        pend_lane_q <= byte_lane;
        if (ar_hs) begin
            rid_q <= arid;
        end
        if (ar_hs || r_hs) begin
            beat_q <= '0; // unused lanes read as zero.
        end else if (pend_q) begin
            beat_q[8*pend_lane_q +: 8] <= ram.rdata_a;
        end
    end

    a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast)
            && $stable(rresp) && $stable(rid))
        else $error("R beat changed before handshake");

endmodule : rd_channel_fsm

`default_nettype wire

// File: wr_channel_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module wr_channel_fsm
    import axi_pkg::*;
    import bridge_pkg::*;
#(
    parameter int ADDR_WIDTH = 12,
    parameter int DATA_WIDTH = 32,
    parameter int ID_WIDTH   = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [ID_WIDTH-1:0]     awid,
    input  logic [ADDR_WIDTH-1:0]   awaddr,
    input  logic [AXI_LEN_W-1:0]    awlen,
    input  logic [AXI_SIZE_W-1:0]   awsize,
    input  burst_e                  awburst,
    input  logic                    wvalid,
    output logic                    wready,
    input  logic [DATA_WIDTH-1:0]   wdata,
    input  logic [DATA_WIDTH/8-1:0] wstrb,
    input  logic                    wlast,
    output logic                    bvalid,
    input  logic                    bready,
    output logic [ID_WIDTH-1:0]     bid,
    output resp_e                   bresp,
    ram_if.wr                       ram
);

    localparam int LANE_W = $clog2(DATA_WIDTH / 8);

    chan_state_e             state;
    chan_state_e             state_nxt;
    logic                    wrap_q;
    logic [ID_WIDTH-1:0]     bid_q;
    logic [DATA_WIDTH-1:0]   wdata_q;
    logic [DATA_WIDTH/8-1:0] strb_q;
    logic                    aw_hs;
    logic                    w_hs;
    logic                    b_hs;
    logic                    cnt_step;
    logic [ADDR_WIDTH-1:0]   byte_addr;
    logic [LANE_W-1:0]       byte_lane;
    logic                    last_byte;
    logic                    last_beat;

    assign aw_hs    = awvalid && awready;
    assign w_hs     = wvalid && wready;
    assign b_hs     = bvalid && bready;
    assign cnt_step = (state == XFER); // one byte per cycle.

    assign awready = (state == IDLE);
    assign wready  = (state == WAIT_DATA);
    assign bvalid  = (state == RESP);
    assign bid     = bid_q;
    assign bresp   = resp_e'(wrap_q ? SLVERR : OKAY);

    assign ram.addr_b  = byte_addr;
    assign ram.wdata_b = wdata_q[8*byte_lane +: 8];
    assign ram.we_b    = (state == XFER) && strb_q[byte_lane];

    beat_counter #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_beat_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (aw_hs),
        .step       (cnt_step),
        .start_addr (awaddr),
        .len        (awlen),
        .size       (awsize),
        .burst      (awburst),
        .byte_addr  (byte_addr),
        .byte_lane  (byte_lane),
        .last_byte  (last_byte),
        .last_beat  (last_beat)
    );

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (aw_hs) begin
                    state_nxt = WAIT_DATA;
                end
            end
            WAIT_DATA: begin
                if (w_hs) begin
                    state_nxt = XFER;
                end
            end
            XFER: begin
                if (last_byte) begin
                    if (last_beat) begin
                        state_nxt = RESP;
                    end else begin
                        state_nxt = WAIT_DATA;
                    end
                end
            end
            RESP: begin
                if (b_hs) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            wrap_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (aw_hs) begin
                wrap_q <= (awburst == WRAP);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            bid_q <= awid;
        end
        if (w_hs) begin
            wdata_q <= wdata;
            strb_q  <= wrap_q ? '0 : wstrb; // wrap beats still step, but write nothing.
        end
    end

    a_wlast_match: assert property (@(posedge clk) disable iff (!rst_n)
        w_hs |-> (wlast == last_beat))
        else $error("WLAST does not match burst length");

endmodule : wr_channel_fsm

`default_nettype wire

// File: axi_ram_top.sv
`timescale 1ns/1ps
`default_nettype none

module axi_ram_top
    import axi_pkg::*;
#(
    parameter int ADDR_WIDTH = 12,
    parameter int DATA_WIDTH = 32,
    parameter int ID_WIDTH   = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    arvalid,
    output logic                    arready,
    input  logic [ID_WIDTH-1:0]     arid,
    input  logic [ADDR_WIDTH-1:0]   araddr,
    input  logic [AXI_LEN_W-1:0]    arlen,
    input  logic [AXI_SIZE_W-1:0]   arsize,
    input  burst_e                  arburst,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [ID_WIDTH-1:0]     rid,
    output logic [DATA_WIDTH-1:0]   rdata,
    output resp_e                   rresp,
    output logic                    rlast,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [ID_WIDTH-1:0]     awid,
    input  logic [ADDR_WIDTH-1:0]   awaddr,
    input  logic [AXI_LEN_W-1:0]    awlen,
    input  logic [AXI_SIZE_W-1:0]   awsize,
    input  burst_e                  awburst,
    input  logic                    wvalid,
    output logic                    wready,
    input  logic [DATA_WIDTH-1:0]   wdata,
    input  logic [DATA_WIDTH/8-1:0] wstrb,
    input  logic                    wlast,
    output logic                    bvalid,
    input  logic                    bready,
    output logic [ID_WIDTH-1:0]     bid,
    output resp_e                   bresp
);

    ram_if #(.ADDR_WIDTH(ADDR_WIDTH)) ram_bus ();

    byte_ram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_byte_ram (
        .clk (clk),
        .mem (ram_bus.mem)
    );

    // read side owns ram port a.
    rd_channel_fsm #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .ID_WIDTH   (ID_WIDTH)
    ) u_rd_channel_fsm (
        .clk     (clk),
        .rst_n   (rst_n),
        .arvalid (arvalid),
        .arready (arready),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .rvalid  (rvalid),
        .rready  (rready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .ram     (ram_bus.rd)
    );

    // write side owns ram port b.
    wr_channel_fsm #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .ID_WIDTH   (ID_WIDTH)
    ) u_wr_channel_fsm (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awid    (awid),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .awsize  (awsize),
        .awburst (awburst),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wlast   (wlast),
        .bvalid  (bvalid),
        .bready  (bready),
        .bid     (bid),
        .bresp   (bresp),
        .ram     (ram_bus.wr)
    );

endmodule : axi_ram_top

`default_nettype wire

// File: tb_axi_ram.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_ram
    import axi_pkg::*;
();

    localparam int ADDR_WIDTH = 12;
    localparam int DATA_WIDTH = 32;
    localparam int ID_WIDTH   = 4;
    localparam int NBYTES     = DATA_WIDTH / 8;
    localparam int DEPTH      = 2 ** ADDR_WIDTH;
    localparam int TIMEOUT    = 20000;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    arvalid;
    logic                    arready;
    logic [ID_WIDTH-1:0]     arid;
    logic [ADDR_WIDTH-1:0]   araddr;
    logic [AXI_LEN_W-1:0]    arlen;
    logic [AXI_SIZE_W-1:0]   arsize;
    burst_e                  arburst;
    logic                    rvalid;
    logic                    rready;
    logic [ID_WIDTH-1:0]     rid;
    logic [DATA_WIDTH-1:0]   rdata;
    resp_e                   rresp;
    logic                    rlast;
    logic                    awvalid;
    logic                    awready;
    logic [ID_WIDTH-1:0]     awid;
    logic [ADDR_WIDTH-1:0]   awaddr;
    logic [AXI_LEN_W-1:0]    awlen;
    logic [AXI_SIZE_W-1:0]   awsize;
    burst_e                  awburst;
    logic                    wvalid;
    logic                    wready;
    logic [DATA_WIDTH-1:0]   wdata;
    logic [NBYTES-1:0]       wstrb;
    logic                    wlast;
    logic                    bvalid;
    logic                    bready;
    logic [ID_WIDTH-1:0]     bid;
    resp_e                   bresp;

    logic [7:0]              model [DEPTH]; // reference copy of the ram.
    logic [ID_WIDTH-1:0]     rd_id;
    int                      rd_addr;
    int                      rd_len;
    int                      rd_size;
    burst_e                  rd_burst;
    resp_e                   rd_resp;
    int                      rd_beat;
    logic [ID_WIDTH-1:0]     wr_id;
    resp_e                   wr_resp;

    always #5 clk = ~clk;

    axi_ram_top #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .ID_WIDTH   (ID_WIDTH)
    ) u_axi_ram_top (.*);

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_beat <= 0;
        end else if (arvalid && arready) begin
            rd_beat <= 0;
        end else if (rvalid && rready) begin
            rd_beat <= rd_beat + 1; // beat index of the next R transfer.
        end
    end

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [DATA_WIDTH-1:0] expected_rdata(input int beat);
        logic [DATA_WIDTH-1:0] data;
        int                    base;
        int                    a;
        int                    i;
        data = '0;
        if (rd_burst != WRAP) begin
            base = (rd_burst == FIXED) ? rd_addr : rd_addr + beat * (1 << rd_size);
            for (i = 0; i < (1 << rd_size); i++) begin
                a = (base + i) % DEPTH;
                data[8*(a % NBYTES) +: 8] = model[a]; // lane from the address offset.
            end
        end
        return data;
    endfunction

    task automatic store_beat(input int addr, input int size, input burst_e burst,
                              input int beat, input logic [DATA_WIDTH-1:0] data,
                              input logic [NBYTES-1:0] strb);
        int base;
        int a;
        int i;
        if (burst != WRAP) begin
            base = (burst == FIXED) ? addr : addr + beat * (1 << size);
            for (i = 0; i < (1 << size); i++) begin
                a = (base + i) % DEPTH;
                if (strb[a % NBYTES]) begin
                    model[a] = data[8*(a % NBYTES) +: 8];
                end
            end
        end
    endtask

    task automatic read_burst(input logic [ID_WIDTH-1:0] id, input int addr, input int len,
                              input int size, input burst_e burst);
        int guard;
        int beats;
        rd_id    = id;
        rd_addr  = addr;
        rd_len   = len;
        rd_size  = size;
        rd_burst = burst;
        rd_resp  = (burst == WRAP) ? SLVERR : OKAY;
        arid     = id;
        araddr   = addr[ADDR_WIDTH-1:0];
        arlen    = len[AXI_LEN_W-1:0];
        arsize   = size[AXI_SIZE_W-1:0];
        arburst  = burst;
        arvalid  = 1'b1;
        guard    = 0;
        while (!arready) begin
            next_cycle();
            guard++;
            if (guard > TIMEOUT) begin
                stop_with_error("timeout waiting for ARREADY");
            end
        end
        next_cycle();
        arvalid = 1'b0;
        beats   = 0;
        guard   = 0;
        while (beats <= len) begin
            rready = ($urandom_range(3) != 0); // stall about one cycle in four.
            if (rvalid && rready) begin
                beats++;
            end
            next_cycle();
            guard++;
            if (guard > TIMEOUT) begin
                stop_with_error("timeout waiting for the R beats of a read burst");
            end
        end
        rready = 1'b0;
    endtask

    task automatic write_burst(input logic [ID_WIDTH-1:0] id, input int addr, input int len,
                               input int size, input burst_e burst, input bit rand_strb);
        int                    guard;
        int                    beat;
        bit                    done;
        logic [DATA_WIDTH-1:0] data;
        logic [NBYTES-1:0]     strb;
        wr_id   = id;
        wr_resp = (burst == WRAP) ? SLVERR : OKAY;
        awid    = id;
        awaddr  = addr[ADDR_WIDTH-1:0];
        awlen   = len[AXI_LEN_W-1:0];
        awsize  = size[AXI_SIZE_W-1:0];
        awburst = burst;
        awvalid = 1'b1;
        guard   = 0;
        while (!awready) begin
            next_cycle();
            guard++;
            if (guard > TIMEOUT) begin
                stop_with_error("timeout waiting for AWREADY");
            end
        end
        next_cycle();
        awvalid = 1'b0;
        for (beat = 0; beat <= len; beat++) begin
            data   = $urandom;
            strb   = rand_strb ? NBYTES'($urandom) : '1;
            wdata  = data;
            wstrb  = strb;
            wlast  = (beat == len);
            wvalid = 1'b1;
            guard  = 0;
            while (!wready) begin
                next_cycle();
                guard++;
                if (guard > TIMEOUT) begin
                    stop_with_error("timeout waiting for WREADY");
                end
            end
            store_beat(addr, size, burst, beat, data, strb);
            next_cycle();
            wvalid = 1'b0;
        end
        done  = 1'b0;
        guard = 0;
        while (!done) begin
            bready = ($urandom_range(3) != 0);
            done   = bvalid && bready;
            next_cycle();
            guard++;
            if (guard > TIMEOUT) begin
                stop_with_error("timeout waiting for the B response");
            end
        end
        bready = 1'b0;
    endtask

    a_reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> arready && awready && !rvalid && !bvalid && !wready)
        else stop_with_error($sformatf("[FAIL] %0t: channels not idle after reset", $time));

    a_r_data: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && rready |-> rdata == expected_rdata(rd_beat))
        else stop_with_error($sformatf("[FAIL] %0t: RDATA %h on beat %0d, expected %h",
            $time, $sampled(rdata), $sampled(rd_beat), expected_rdata($sampled(rd_beat))));

    a_r_attr: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && rready |-> rid == rd_id && rresp == rd_resp)
        else stop_with_error($sformatf("[FAIL] %0t: wrong RID or RRESP", $time));

    a_r_last: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && rready |-> rlast == (rd_beat == rd_len))
        else stop_with_error($sformatf("[FAIL] %0t: RLAST wrong on beat %0d", $time,
            $sampled(rd_beat)));

    a_b_resp: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && bready |-> bresp == wr_resp && bid == wr_id)
        else stop_with_error($sformatf("[FAIL] %0t: wrong BID or BRESP", $time));

    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast)
            && $stable(rresp) && $stable(rid))
        else stop_with_error($sformatf("[FAIL] %0t: R beat changed while stalled", $time));

    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp))
        else stop_with_error($sformatf("[FAIL] %0t: B response changed while stalled", $time));

    initial begin
        int len;
        int idx;
        void'($urandom(55901));
        rst_n    = 1'b0;
        arvalid  = 1'b0;
        arid     = '0;
        araddr   = '0;
        arlen    = '0;
        arsize   = '0;
        arburst  = INCR;
        rready   = 1'b0;
        awvalid  = 1'b0;
        awid     = '0;
        awaddr   = '0;
        awlen    = '0;
        awsize   = '0;
        awburst  = INCR;
        wvalid   = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wlast    = 1'b0;
        bready   = 1'b0;
        rd_id    = '0;
        rd_addr  = 0;
        rd_len   = 0;
        rd_size  = 0;
        rd_burst = INCR;
        rd_resp  = OKAY;
        wr_id    = '0;
        wr_resp  = OKAY;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();

        write_burst(4'h3, 'h100, 7, 2, INCR, 1'b0);
        read_burst(4'h5, 'h100, 7, 2, INCR);
        write_burst(4'h9, 'h200, 15, 2, INCR, 1'b0);
        read_burst(4'ha, 'h200, 15, 2, INCR);

        // narrow bursts over the region written above.
        write_burst(4'h1, 'h101, 5, 0, INCR, 1'b1);
        write_burst(4'h2, 'h108, 3, 1, INCR, 1'b1);
        read_burst(4'h4, 'h101, 6, 0, INCR);
        read_burst(4'h6, 'h104, 5, 1, INCR);

        write_burst(4'h7, 'h110, 3, 2, FIXED, 1'b1);
        read_burst(4'h8, 'h110, 3, 2, FIXED);
        read_burst(4'hb, 'h10e, 2, 1, FIXED);

        // wrap is refused and must leave 0x100 untouched.
        read_burst(4'hc, 'h100, 3, 2, WRAP);
        write_burst(4'hd, 'h100, 3, 2, WRAP, 1'b0);
        read_burst(4'he, 'h100, 7, 2, INCR);

        fork
            write_burst(4'h2, 'h400, 15, 2, INCR, 1'b0);
            read_burst(4'h3, 'h200, 15, 2, INCR);
        join
        read_burst(4'h4, 'h400, 15, 2, INCR);

        for (idx = 0; idx < 6; idx++) begin
            len = $urandom_range(31);
            write_burst(ID_WIDTH'(idx), 'h600 + idx * 'h80, len, 2, INCR, 1'b0);
            read_burst(ID_WIDTH'(idx + 8), 'h600 + idx * 'h80, len, 2, INCR);
        end
        write_burst(4'hf, 'ha00, 255, 2, INCR, 1'b0); // longest legal burst.
        read_burst(4'h0, 'ha00, 255, 2, INCR);

        $display("Testbench passed");
        $finish;
    end

endmodule : tb_axi_ram

`default_nettype wire

// File: src.f
axi_pkg.sv
bridge_pkg.sv
ram_if.sv
byte_ram.sv
beat_counter.sv
rd_channel_fsm.sv
wr_channel_fsm.sv
axi_ram_top.sv
tb_axi_ram.sv

// File: Bender.yml
package:
  name: axi_ram_bridge

sources:
  - files:
      - axi_pkg.sv
      - bridge_pkg.sv
      - ram_if.sv
      - byte_ram.sv
      - beat_counter.sv
      - rd_channel_fsm.sv
      - wr_channel_fsm.sv
      - axi_ram_top.sv
  - target: simulation
    files:
      - tb_axi_ram.sv
